//--- src.f
design/math_pkg.sv
design/color_pkg.sv
design/screen_filler.sv
design/fb_writer.sv
design/fb_ram.sv
design/gfx_fill_top.sv
dv/tb_gfx_fill.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_gfx_fill
DESIGN_TOP ?= gfx_fill_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= ALL TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DESIGN_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the run fails unless the pass line shows up in the output
sim: build
	@out="$$(./$(SIM_BIN))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

//--- dv/tb_gfx_fill.sv
module tb_gfx_fill import math_pkg::*, color_pkg::*;;
    localparam int WIDTH       = 16;
    localparam int HEIGHT      = 8;
    localparam int DEPTH       = WIDTH * HEIGHT;
    localparam int AW          = addr_bits(WIDTH, HEIGHT);
    localparam int N_ROWS      = 5;
    localparam int CLK_HALF    = 20;
    localparam int DRIVE_DELAY = 2;

    logic          clk;
    logic          rst;
    color12_t      fill_color;
    logic          fill_valid;
    logic          fill_ready;
    logic          rd_cyc;
    logic          rd_stb;
    logic [AW-1:0] rd_adr;
    color12_t      rd_dat;
    logic          rd_ack;
    logic          busy;

    // each row is one fill, and a held row first runs the inverse colour with its own queued
    color12_t row_color [N_ROWS];
    int       row_samples [N_ROWS];
    logic     row_held [N_ROWS];

    int          pass_count;
    int          fail_count;
    int          test_errors;
    int          cycle_count;
    int          cycle_limit;
    string       wait_name;
    logic [31:0] rng_state;

    gfx_fill_top #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) uut (
        .clk       (clk),
        .rst       (rst),
        .fill_color(fill_color),
        .fill_valid(fill_valid),
        .fill_ready(fill_ready),
        .rd_cyc    (rd_cyc),
        .rd_stb    (rd_stb),
        .rd_adr    (rd_adr),
        .rd_dat    (rd_dat),
        .rd_ack    (rd_ack),
        .busy      (busy)
    );

    always #CLK_HALF clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles while waiting for %s", cycle_count, wait_name);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_color(color12_t observed, color12_t expected, string what);
        if (observed !== expected) begin
            $display("Error at time %0t: %s, got %h expected %h", $time, what, observed, expected);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_bit(logic observed, logic expected, string what);
        if (observed !== expected) begin
            $display("Error at time %0t: %s, got %b expected %b", $time, what, observed, expected);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic load_table();
        row_color[0] = make_color(4'hf, 4'h0, 4'h0);
        row_color[1] = make_color(4'h0, 4'hf, 4'h0);
        row_color[2] = make_color(4'h0, 4'h0, 4'hf);
        row_color[3] = make_color(4'h5, 4'ha, 4'h3);
        row_color[4] = make_color(4'hc, 4'h6, 4'h9);
        row_samples  = '{6, 6, 4, 8, 5};
        row_held     = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    endtask

    // a fill costs three cycles per pixel and a readback three, so four of each is ample
    function automatic int run_budget();
        int total;
        total = 200;
        for (int r = 0; r < N_ROWS; r++) begin
            total += (row_held[r] ? 2 : 1) * 4 * DEPTH + 4 * (4 + row_samples[r]);
        end
        return total;
    endfunction

    task automatic start_fill(color12_t c);
        fill_color = c;
        fill_valid = 1'b1;
        wait_name  = "fill_ready to accept a request";
        while (!fill_ready) begin
            step();
        end
        step();
        fill_valid = 1'b0;
        check_bit(busy, 1'b1, "busy after fill accepted");
    endtask

    // the filler cannot finish its walk within one cycle per pixel
    task automatic watch_fill();
        for (int i = 0; i < DEPTH; i++) begin
            step();
            check_bit(busy, 1'b1, "busy during fill");
            check_bit(fill_ready, 1'b0, "fill_ready during fill");
        end
    endtask

    task automatic wait_idle();
        wait_name = "busy to fall after a fill";
        while (busy) begin
            step();
        end
        check_bit(fill_ready, 1'b1, "fill_ready once idle");
    endtask

    // the strobe stays up through the edge that samples the ack, as a classic master does
    task automatic read_word(int addr, output color12_t data);
        check_bit(rd_ack, 1'b0, "rd_ack before strobe");
        rd_adr = AW'(addr);
        rd_cyc = 1'b1;
        rd_stb = 1'b1;
        step();
        check_bit(rd_ack, 1'b1, "rd_ack one cycle after strobe");
        data = rd_dat;
        step();
        check_bit(rd_ack, 1'b0, "single rd_ack per strobe");
        rd_cyc = 1'b0;
        rd_stb = 1'b0;
        step();
    endtask

    task automatic verify_location(int addr, color12_t expected, color12_t previous, logic has_prev);
        color12_t got;
        read_word(addr, got);
        check_color(got, expected, $sformatf("readback at address %0d", addr));
        if (has_prev) begin
            check_bit(got !== previous, 1'b1, $sformatf("old colour left at address %0d", addr));
        end
    endtask

    initial begin
        color12_t prev_color;
        color12_t first_color;
        logic     has_prev;
        int       corners [4];
        clk         = 1'b0;
        rst         = 1'b1;
        fill_color  = '0;
        fill_valid  = 1'b0;
        rd_cyc      = 1'b0;
        rd_stb      = 1'b0;
        rd_adr      = '0;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        cycle_count = 0;
        rng_state   = 32'hcead;
        wait_name   = "reset";
        has_prev    = 1'b0;
        prev_color  = '0;
        load_table();
        cycle_limit = run_budget();
        corners = '{0, WIDTH - 1, (HEIGHT - 1) * WIDTH, (HEIGHT - 1) * WIDTH + WIDTH - 1};

        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_bit(busy, 1'b0, "busy after reset");
        check_bit(fill_ready, 1'b1, "fill_ready after reset");
        check_bit(rd_ack, 1'b0, "rd_ack after reset");
        $display("test reset: %s", (test_errors == 0) ? "ok" : "failed");

        for (int r = 0; r < N_ROWS; r++) begin
            test_errors = 0;
            if (row_held[r]) begin
                first_color = ~row_color[r];
                start_fill(first_color);
                // queue the row colour while the first fill runs
                fill_color = row_color[r];
                fill_valid = 1'b1;
                watch_fill();
                wait_name = "fill_ready to take the held request";
                while (!fill_ready) begin
                    step();
                end
                step();
                fill_valid = 1'b0;
                check_bit(busy, 1'b1, "busy after held request taken");
                watch_fill();
                prev_color = first_color;
                has_prev   = 1'b1;
            end else begin
                start_fill(row_color[r]);
                watch_fill();
            end
            wait_idle();
            for (int c = 0; c < 4; c++) begin
                verify_location(corners[c], row_color[r], prev_color, has_prev);
            end
            for (int s = 0; s < row_samples[r]; s++) begin
                rng_state = next_random(rng_state);
                verify_location(int'(rng_state % 32'(DEPTH)), row_color[r], prev_color, has_prev);
            end
            $display("test %0d colour %h held %b: %s (%0d errors)", r, row_color[r], row_held[r],
                     (test_errors == 0) ? "ok" : "failed", test_errors);
            prev_color = row_color[r];
            has_prev   = 1'b1;
        end

        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- design/gfx_fill_top.sv
module gfx_fill_top import math_pkg::*, color_pkg::*; #(
    parameter  int WIDTH  = 16,
    parameter  int HEIGHT = 8,
    localparam int AW     = addr_bits(WIDTH, HEIGHT)
) (
    input  logic          clk,
    input  logic          rst,
    input  color12_t      fill_color,
    input  logic          fill_valid,
    output logic          fill_ready,
    input  logic          rd_cyc,
    input  logic          rd_stb,
    input  logic [AW-1:0] rd_adr,
    output color12_t      rd_dat,
    output logic          rd_ack,
    output logic          busy
);
    // black until the first request arrives
    localparam color12_t RESET_COLOR = make_color(4'h0, 4'h0, 4'h0);

    coord_t        pix_x;
    coord_t        pix_y;
    color12_t      pix_color;
    logic          pix_valid;
    logic          pix_ready;
    logic          filler_busy;
    logic          writer_busy;
    logic          wr_cyc;
    logic          wr_stb;
    logic          wr_we;
    logic [AW-1:0] wr_adr;
    color12_t      wr_dat;
    logic          wr_ack;

    assign busy = filler_busy || writer_busy;

    screen_filler #(
        .WIDTH      (WIDTH),
        .HEIGHT     (HEIGHT),
        .RESET_COLOR(RESET_COLOR)
    ) u_filler (
        .clk        (clk),
        .rst        (rst),
        .fill_color (fill_color),
        .in_valid   (fill_valid),
        .in_ready   (fill_ready),
        .out_pixel_x(pix_x),
        .out_pixel_y(pix_y),
        .out_color  (pix_color),
        .out_valid  (pix_valid),
        .out_ready  (pix_ready),
        .busy       (filler_busy)
    );

    fb_writer #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_writer (
        .clk      (clk),
        .rst      (rst),
        .pix_x    (pix_x),
        .pix_y    (pix_y),
        .pix_color(pix_color),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .wb_cyc   (wr_cyc),
        .wb_stb   (wr_stb),
        .wb_we    (wr_we),
        .wb_adr   (wr_adr),
        .wb_dat   (wr_dat),
        .wb_ack   (wr_ack),
        .busy     (writer_busy)
    );

    fb_ram #(.WIDTH(WIDTH), .HEIGHT(HEIGHT)) u_ram (
        .clk   (clk),
        .rst   (rst),
        .wr_cyc(wr_cyc),
        .wr_stb(wr_stb),
        .wr_we (wr_we),
        .wr_adr(wr_adr),
        .wr_dat(wr_dat),
        .wr_ack(wr_ack),
        .rd_cyc(rd_cyc),
        .rd_stb(rd_stb),
        .rd_adr(rd_adr),
        .rd_dat(rd_dat),
        .rd_ack(rd_ack)
    );

endmodule

//--- design/fb_ram.sv
module fb_ram import math_pkg::*, color_pkg::*; #(
    parameter  int WIDTH  = 16,
    parameter  int HEIGHT = 8,
    localparam int AW     = addr_bits(WIDTH, HEIGHT)
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          wr_cyc,
    input  logic          wr_stb,
    input  logic          wr_we,
    input  logic [AW-1:0] wr_adr,
    input  color12_t      wr_dat,
    output logic          wr_ack,
    input  logic          rd_cyc,
    input  logic          rd_stb,
    input  logic [AW-1:0] rd_adr,
    output color12_t      rd_dat,
    output logic          rd_ack
);
    localparam int DEPTH = WIDTH * HEIGHT;

    color12_t mem [DEPTH];
    logic     wr_req;
    logic     rd_req;

    // a held strobe is answered once, the ack itself masks the second cycle
    assign wr_req = wr_cyc && wr_stb && !wr_ack;
    assign rd_req = rd_cyc && rd_stb && !rd_ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_req;
            rd_ack <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_req && wr_we && (int'(wr_adr) < DEPTH)) begin
            mem[wr_adr] <= wr_dat;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_dat <= (int'(rd_adr) < DEPTH) ? mem[rd_adr] : '0;
        end
    end

    a_wr_ack: assert property (@(posedge clk) disable iff (rst) wr_ack |-> $past(wr_stb))
        else $error("write ack without a strobe");

endmodule

//--- design/fb_writer.sv
module fb_writer import math_pkg::*, color_pkg::*; #(
    parameter  int WIDTH  = 16,
    parameter  int HEIGHT = 8,
    localparam int AW     = addr_bits(WIDTH, HEIGHT)
) (
    input  logic          clk,
    input  logic          rst,
    input  coord_t        pix_x,
    input  coord_t        pix_y,
    input  color12_t      pix_color,
    input  logic          pix_valid,
    output logic          pix_ready,
    output logic          wb_cyc,
    output logic          wb_stb,
    output logic          wb_we,
    output logic [AW-1:0] wb_adr,
    output color12_t      wb_dat,
    input  logic          wb_ack,
    output logic          busy
);
    // write issues the strobe and finish holds it until the slave answers
    typedef enum logic [1:0] {IDLE, WRITE, FINISH} state_t;

    state_t state;
    logic   take;

    assign pix_ready = (state == IDLE);
    assign take      = pix_valid && pix_ready;

    assign wb_cyc = (state != IDLE);
    assign wb_stb = (state != IDLE);
    // this master only ever writes
    assign wb_we  = (state != IDLE);
    assign busy   = (state != IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (take) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    state <= wb_ack ? IDLE : FINISH;
                end
                FINISH: begin
                    if (wb_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            wb_adr <= AW'(linear_addr(pix_x, pix_y, WIDTH));
            wb_dat <= pix_color;
        end
    end

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_cyc)
        else $error("ack outside a bus cycle");

    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        wb_stb && !wb_ack |=> $stable(wb_adr) && $stable(wb_dat))
        else $error("write request changed before ack");

endmodule

//--- design/screen_filler.sv
module screen_filler import math_pkg::*, color_pkg::*; #(
    parameter int       WIDTH       = 16,
    parameter int       HEIGHT      = 8,
    parameter color12_t RESET_COLOR = '0
) (
    input  logic     clk,
    input  logic     rst,
    input  color12_t fill_color,
    input  logic     in_valid,
    output logic     in_ready,
    output coord_t   out_pixel_x,
    output coord_t   out_pixel_y,
    output color12_t out_color,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     busy
);
    typedef enum logic [0:0] {IDLE, RUN} state_t;

    state_t   state;
    state_t   state_nxt;
    coord_t   cur_x;
    coord_t   cur_y;
    coord_t   x_nxt;
    coord_t   y_nxt;
    color12_t color_reg;
    coord_t   x_reg;
    coord_t   y_reg;
    color12_t color_out_reg;
    logic     valid_reg;
    logic     accept;
    logic     emit;
    logic     drain;

    assign accept = in_valid && in_ready;
    // the output stage takes a new location when it is empty or being drained
    assign emit  = (state == RUN) && (!valid_reg || out_ready);
    assign drain = valid_reg && out_ready;

    assign in_ready    = (state == IDLE);
    assign busy        = (state != IDLE) || valid_reg;
    assign out_valid   = valid_reg;
    assign out_pixel_x = x_reg;
    assign out_pixel_y = y_reg;
    assign out_color   = color_out_reg;

    always_comb begin
        state_nxt = state;
        x_nxt     = cur_x;
        y_nxt     = cur_y;
        unique case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = RUN;
                    x_nxt     = '0;
                    y_nxt     = '0;
                end
            end
            RUN: begin
                if (emit) begin
                    if (int'(cur_x) < WIDTH - 1) begin
                        x_nxt = cur_x + 16'd1;
                    end else begin
                        x_nxt = '0;
                        if (int'(cur_y) < HEIGHT - 1) begin
                            y_nxt = cur_y + 16'd1;
                        end else begin
                            // last location goes out on this edge
                            state_nxt = IDLE;
                        end
                    end
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            cur_x     <= '0;
            cur_y     <= '0;
            valid_reg <= 1'b0;
            color_reg <= RESET_COLOR;
        end else begin
            state <= state_nxt;
            cur_x <= x_nxt;
            cur_y <= y_nxt;
            if (accept) begin
                color_reg <= fill_color;
            end
            if (emit) begin
                valid_reg <= 1'b1;
            end else if (drain) begin
                valid_reg <= 1'b0;
            end
        end
    end

    // colour travels with each pixel so a new request cannot alter a held item
    always_ff @(posedge clk) begin
        if (emit) begin
            x_reg         <= cur_x;
            y_reg         <= cur_y;
            color_out_reg <= color_reg;
        end
    end

    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_pixel_x)
            && $stable(out_pixel_y) && $stable(out_color))
        else $error("pixel changed while stalled");

endmodule

//--- design/color_pkg.sv
package color_pkg;

    // red in the top nibble, then green, then blue
    typedef logic [11:0] color12_t;

    function automatic color12_t make_color(logic [3:0] r, logic [3:0] g, logic [3:0] b);
        return {r, g, b};
    endfunction

    function automatic logic [3:0] red_of(color12_t c);
        return c[11:8];
    endfunction

    function automatic logic [3:0] green_of(color12_t c);
        return c[7:4];
    endfunction

    function automatic logic [3:0] blue_of(color12_t c);
        return c[3:0];
    endfunction

endpackage

//--- design/math_pkg.sv
package math_pkg;

    // one pixel coordinate on either axis
    typedef logic [15:0] coord_t;

    // bits needed to address every cell of the raster, never less than one
    function automatic int addr_bits(int width, int height);
        longint cells;
        cells = longint'(width) * longint'(height);
        return (cells > 1) ? $clog2(cells) : 1;
    endfunction

    // row-major layout, x steps fastest
    function automatic logic [31:0] linear_addr(coord_t x, coord_t y, int width);
        logic [31:0] row_base;
        row_base = 32'(y) * 32'(width);
        return row_base + 32'(x);
    endfunction

endpackage
